/* design/branch_resolve.sv */
`include "core_params.svh"

module branch_resolve
  import isa_pkg::*;
(
  input  logic             clk,
  input  logic             rstn,
  input  logic             de_st_i,
  input  logic             flush_i,
  input  logic [2:0]       funct3_i,
  input  logic [`XLEN-1:0] rs1_val_i,
  input  logic [`XLEN-1:0] rs2_val_i,
  output logic             cond_true_o
);

  logic [2:0] funct3_q;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  // Condition code follows the instruction into execute.
  always_ff @(posedge clk)
  begin
    if (!rstn)
      funct3_q <= `FUNCT3_RST;
    else if (de_st_i)
      funct3_q <= funct3_q;
    else if (flush_i)
      funct3_q <= `FUNCT3_RST;
    else
      funct3_q <= funct3_i;
  end

  assign eq   = (rs1_val_i == rs2_val_i);
  assign lt_s = $signed(rs1_val_i) < $signed(rs2_val_i);
  assign lt_u = rs1_val_i < rs2_val_i;

  // Raw compare; hazard control decides if a branch is there.
  always_comb
  begin
    case (funct3_q)
      F3_BEQ:  cond_true_o = eq;
      F3_BNE:  cond_true_o = !eq;
      F3_BLT:  cond_true_o = lt_s;
      F3_BGE:  cond_true_o = !lt_s;
      F3_BLTU: cond_true_o = lt_u;
      F3_BGEU: cond_true_o = !lt_u;
      default: cond_true_o = 1'b0;
    endcase
  end

endmodule

/* design/core_params.svh */
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and register file geometry.
`define XLEN     32
`define REG_AW   5
`define INSTR_W  32

// Reset values of the execute-stage registers.
`define OPND_RST   {`XLEN{1'b0}}
`define FUNCT3_RST 3'b000

`endif

/* design/hazard_ctrl.sv */
`include "core_params.svh"

module hazard_ctrl
  import pipe_ctrl_pkg::*;
(
  input  logic               clk,
  input  logic               rstn,
  input  logic               is_branch_i,
  input  logic               is_jump_i,
  input  logic               is_load_i,
  input  logic               is_mul_i,
  input  logic               is_div_i,
  input  logic               dst_en_i,
  input  logic               mret_i,
  input  logic               fin_i,
  input  logic               pre_taken_i,
  input  logic               real_taken_i,
  input  logic               trap_flush_i,
  input  logic               f_cmiss_i,
  input  logic               m_cmiss_i,
  input  logic               f_arrival_i,
  input  logic               m_arrival_i,
  input  logic [`REG_AW-1:0] r_dst_i,
  input  logic [`REG_AW-1:0] r_src1_i,
  input  logic [`REG_AW-1:0] r_src2_i,
  output fwd_sel_e           src1_sel_o,
  output fwd_sel_e           src2_sel_o,
  output logic               fd_st_o,
  output logic               de_st_o,
  output logic               em_st_o,
  output logic               flush_o,
  output logic               rs1_depended_o,
  output logic               ptnt_early_o,
  output logic               bnt_taken_o,
  output logic               bptrt_o,
  output logic               bptnt_o
);

  logic [`REG_AW-1:0] dst_1;
  logic [`REG_AW-1:0] dst_2;
  logic               ld_1;
  logic               trap_flush_q;
  logic               imiss_keep;
  logic               dmiss_keep;
  logic               long_keep;
  logic               imiss_st;
  logic               dmiss_st;
  logic               long_st;
  logic               ldhaz_st;
  logic               flush;
  logic               ctl_ok;
  logic               jd1;
  logic [2:0]         jd_b;
  logic               bpt;
  logic               bnt;
  logic               bptnt;
  logic               bnt1;

  function automatic fwd_sel_e fwd_pick(input logic [`REG_AW-1:0] src,
                                        input logic [`REG_AW-1:0] d1,
                                        input logic [`REG_AW-1:0] d2);
    fwd_sel_e sel;
    sel = FWD_NONE;
    if (src != '0)
    begin
      if (d1 == src)
        sel = FWD_EX;
      else if (d2 == src)
        sel = FWD_MEM;
    end
    return sel;
  endfunction

  always_ff @(posedge clk)
  begin
    if (!rstn)
      trap_flush_q <= 1'b0;
    else
      trap_flush_q <= trap_flush_i;
  end

  // Destinations of the instructions in execute and memory.
  always_ff @(posedge clk)
  begin
    if (!rstn || trap_flush_i || trap_flush_q)
    begin
      dst_1 <= '0;
      dst_2 <= '0;
      ld_1  <= 1'b0;
    end
    else if (!dmiss_st)
    begin
      dst_2 <= dst_1;
      if (ldhaz_st)
      begin
        // Bubble into execute while the user waits.
        dst_1 <= '0;
        ld_1  <= 1'b0;
      end
      else
      begin
        dst_1 <= (dst_en_i && !flush) ? r_dst_i : '0;
        ld_1  <= is_load_i && !flush;
      end
    end
  end

  assign src1_sel_o     = fwd_pick(r_src1_i, dst_1, dst_2);
  assign src2_sel_o     = fwd_pick(r_src2_i, dst_1, dst_2);
  assign rs1_depended_o = (src1_sel_o != FWD_NONE);

  assign ldhaz_st = ld_1 && (dst_1 != '0) && ((dst_1 == r_src1_i) || (dst_1 == r_src2_i));
  assign imiss_st = !f_arrival_i && (f_cmiss_i || imiss_keep);
  assign dmiss_st = !m_arrival_i && (m_cmiss_i || dmiss_keep);
  assign long_st  = !(fin_i || flush) && (is_mul_i || is_div_i || long_keep);

  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      imiss_keep <= 1'b0;
      dmiss_keep <= 1'b0;
      long_keep  <= 1'b0;
    end
    else
    begin
      if (fin_i)
        long_keep <= 1'b0;
      else if (!flush && (is_mul_i || is_div_i))
        long_keep <= 1'b1;
      if (f_cmiss_i)
        imiss_keep <= 1'b1;
      else if (f_arrival_i)
        imiss_keep <= 1'b0;
      if (m_cmiss_i)
        dmiss_keep <= 1'b1;
      else if (m_arrival_i)
        dmiss_keep <= 1'b0;
    end
  end

  assign fd_st_o = long_st || imiss_st || dmiss_st || ldhaz_st;
  assign de_st_o = ldhaz_st || dmiss_st;
  assign em_st_o = dmiss_st;

  // Older redirect already pending, so this one is dropped.
  assign ctl_ok = !(flush || trap_flush_i);

  // Jump and branch history.
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      jd1   <= 1'b0;
      jd_b  <= '0;
      bpt   <= 1'b0;
      bnt   <= 1'b0;
      bptnt <= 1'b0;
      bnt1  <= 1'b0;
    end
    else
    begin
      jd1     <= is_jump_i && ctl_ok;
      jd_b[0] <= is_jump_i && ctl_ok && ((src1_sel_o != FWD_NONE) || (src2_sel_o != FWD_NONE));
      jd_b[2:1] <= jd_b[1:0];
      bpt     <= !is_jump_i && is_branch_i && ctl_ok && pre_taken_i;
      bnt     <= !is_jump_i && is_branch_i && ctl_ok && !pre_taken_i;
      bptnt   <= bpt && !real_taken_i;
      bnt1    <= bnt && real_taken_i;
    end
  end

  assign flush = jd1 || jd_b[2] || bptnt || (bpt && real_taken_i) ||
                 bnt1 || (bnt && real_taken_i) || mret_i;

  assign flush_o      = flush;
  assign ptnt_early_o = bpt && !real_taken_i;
  assign bptrt_o      = bpt && real_taken_i;
  assign bptnt_o      = bptnt;
  assign bnt_taken_o  = bnt1;

endmodule

/* design/instr_decode.sv */
`include "core_params.svh"

module instr_decode
  import isa_pkg::*;
(
  input  logic [`INSTR_W-1:0] instr_i,
  output logic                is_branch_o,
  output logic                is_jump_o,
  output logic                is_load_o,
  output logic                is_mul_o,
  output logic                is_div_o,
  output logic                dst_en_o,
  output logic                is_mret_o,
  output logic [`REG_AW-1:0]  rd_o,
  output logic [`REG_AW-1:0]  rs1_o,
  output logic [`REG_AW-1:0]  rs2_o,
  output logic [2:0]          funct3_o
);

  instr_u ins;
  logic   use_rs1;
  logic   use_rs2;
  logic   is_muldiv;

  assign ins = instr_u'(instr_i);

  assign is_muldiv = (ins.r_fmt.opcode == OPC_OP) && (ins.r_fmt.funct7 == FUNCT7_MULDIV);

  always_comb
  begin
    is_branch_o = 1'b0;
    is_jump_o   = 1'b0;
    is_load_o   = 1'b0;
    dst_en_o    = 1'b0;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    case (ins.r_fmt.opcode)
      OPC_LOAD:
      begin
        is_load_o = 1'b1;
        dst_en_o  = 1'b1;
        use_rs1   = 1'b1;
      end
      OPC_OP_IMM:
      begin
        dst_en_o = 1'b1;
        use_rs1  = 1'b1;
      end
      OPC_OP:
      begin
        dst_en_o = 1'b1;
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
      end
      OPC_LUI, OPC_AUIPC:
      begin
        dst_en_o = 1'b1;
      end
      OPC_JAL:
      begin
        is_jump_o = 1'b1;
        dst_en_o  = 1'b1;
      end
      OPC_JALR:
      begin
        is_jump_o = 1'b1;
        dst_en_o  = 1'b1;
        use_rs1   = 1'b1;
      end
      OPC_BRANCH:
      begin
        is_branch_o = 1'b1;
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
      end
      OPC_STORE:
      begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      default:
      begin
        // System and unknown opcodes have no register effects here.
      end
    endcase
  end

  // Low funct3 values are the multiplies.
  assign is_mul_o = is_muldiv && !ins.r_fmt.funct3[2];
  assign is_div_o = is_muldiv && ins.r_fmt.funct3[2];

  assign is_mret_o = (ins.i_fmt.opcode == OPC_SYSTEM) && (ins.i_fmt.funct3 == 3'b000) &&
                     (ins.i_fmt.imm_11_0 == F12_MRET);

  // Unused fields forced to x0 so they never match.
  assign rd_o     = dst_en_o ? ins.r_fmt.rd : '0;
  assign rs1_o    = use_rs1 ? ins.r_fmt.rs1 : '0;
  assign rs2_o    = use_rs2 ? ins.r_fmt.rs2 : '0;
  assign funct3_o = ins.b_fmt.funct3;

endmodule

/* design/isa_pkg.sv */
`include "core_params.svh"

package isa_pkg;

  // Major opcodes.
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  // M extension marker in funct7.
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Branch conditions.
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // SYSTEM immediate of mret.
  localparam logic [11:0] F12_MRET = 12'h302;

  typedef struct packed {
    logic [6:0]         funct7;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]        imm_11_0;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [`REG_AW-1:0] rd;
    logic [6:0]         opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0]         imm_11_5;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [4:0]         imm_4_0;
    logic [6:0]         opcode;
  } s_fmt_t;

  typedef struct packed {
    logic               imm_12;
    logic [5:0]         imm_10_5;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rs1;
    logic [2:0]         funct3;
    logic [3:0]         imm_4_1;
    logic               imm_11;
    logic [6:0]         opcode;
  } b_fmt_t;

  // One instruction word, read in whichever format the opcode calls for.
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
  } instr_u;

endpackage

/* design/pipe_ctrl_pkg.sv */
package pipe_ctrl_pkg;

  // Operand source for the decode-to-execute register.
  // Bit 0 picks the instruction now in execute, bit 1 the one in memory.
  typedef enum logic [1:0] {
    FWD_NONE = 2'b00,
    FWD_EX   = 2'b01,
    FWD_MEM  = 2'b10
  } fwd_sel_e;

endpackage

/* design/pipe_ctrl_top.sv */
`include "core_params.svh"

module pipe_ctrl_top
  import pipe_ctrl_pkg::*;
(
  input  logic                clk,
  input  logic                rstn,
  input  logic [`INSTR_W-1:0] instr_i,
  input  logic                pre_taken_i,
  input  logic                fin_i,
  input  logic                trap_flush_i,
  input  logic                f_cmiss_i,
  input  logic                m_cmiss_i,
  input  logic                f_arrival_i,
  input  logic                m_arrival_i,
  input  logic [`XLEN-1:0]    rf_rs1_i,
  input  logic [`XLEN-1:0]    rf_rs2_i,
  input  logic [`XLEN-1:0]    ex_result_i,
  input  logic [`XLEN-1:0]    mem_result_i,
  output logic                fd_st_o,
  output logic                de_st_o,
  output logic                em_st_o,
  output logic                flush_o,
  output logic                rs1_depended_o,
  output logic                ptnt_early_o,
  output logic                bnt_taken_o,
  output logic                bptrt_o,
  output logic                bptnt_o,
  output logic                real_taken_o,
  output logic [`XLEN-1:0]    exe_rs1_o,
  output logic [`XLEN-1:0]    exe_rs2_o
);

  logic               is_branch;
  logic               is_jump;
  logic               is_load;
  logic               is_mul;
  logic               is_div;
  logic               dst_en;
  logic               is_mret;
  logic [`REG_AW-1:0] rd;
  logic [`REG_AW-1:0] rs1;
  logic [`REG_AW-1:0] rs2;
  logic [2:0]         funct3;
  fwd_sel_e           src1_sel;
  fwd_sel_e           src2_sel;
  logic               cond_true;

  instr_decode u_decode (
    .instr_i     (instr_i),
    .is_branch_o (is_branch),
    .is_jump_o   (is_jump),
    .is_load_o   (is_load),
    .is_mul_o    (is_mul),
    .is_div_o    (is_div),
    .dst_en_o    (dst_en),
    .is_mret_o   (is_mret),
    .rd_o        (rd),
    .rs1_o       (rs1),
    .rs2_o       (rs2),
    .funct3_o    (funct3)
  );

  hazard_ctrl u_hazard (
    .clk            (clk),
    .rstn           (rstn),
    .is_branch_i    (is_branch),
    .is_jump_i      (is_jump),
    .is_load_i      (is_load),
    .is_mul_i       (is_mul),
    .is_div_i       (is_div),
    .dst_en_i       (dst_en),
    .mret_i         (is_mret),
    .fin_i          (fin_i),
    .pre_taken_i    (pre_taken_i),
    .real_taken_i   (cond_true),
    .trap_flush_i   (trap_flush_i),
    .f_cmiss_i      (f_cmiss_i),
    .m_cmiss_i      (m_cmiss_i),
    .f_arrival_i    (f_arrival_i),
    .m_arrival_i    (m_arrival_i),
    .r_dst_i        (rd),
    .r_src1_i       (rs1),
    .r_src2_i       (rs2),
    .src1_sel_o     (src1_sel),
    .src2_sel_o     (src2_sel),
    .fd_st_o        (fd_st_o),
    .de_st_o        (de_st_o),
    .em_st_o        (em_st_o),
    .flush_o        (flush_o),
    .rs1_depended_o (rs1_depended_o),
    .ptnt_early_o   (ptnt_early_o),
    .bnt_taken_o    (bnt_taken_o),
    .bptrt_o        (bptrt_o),
    .bptnt_o        (bptnt_o)
  );

  result_bypass u_bypass (
    .clk          (clk),
    .rstn         (rstn),
    .de_st_i      (de_st_o),
    .flush_i      (flush_o),
    .src1_sel_i   (src1_sel),
    .src2_sel_i   (src2_sel),
    .rf_rs1_i     (rf_rs1_i),
    .rf_rs2_i     (rf_rs2_i),
    .ex_result_i  (ex_result_i),
    .mem_result_i (mem_result_i),
    .exe_rs1_o    (exe_rs1_o),
    .exe_rs2_o    (exe_rs2_o)
  );

  branch_resolve u_branch (
    .clk         (clk),
    .rstn        (rstn),
    .de_st_i     (de_st_o),
    .flush_i     (flush_o),
    .funct3_i    (funct3),
    .rs1_val_i   (exe_rs1_o),
    .rs2_val_i   (exe_rs2_o),
    .cond_true_o (cond_true)
  );

  assign real_taken_o = cond_true;

endmodule

/* design/result_bypass.sv */
`include "core_params.svh"

module result_bypass
  import pipe_ctrl_pkg::*;
(
  input  logic             clk,
  input  logic             rstn,
  input  logic             de_st_i,
  input  logic             flush_i,
  input  fwd_sel_e         src1_sel_i,
  input  fwd_sel_e         src2_sel_i,
  input  logic [`XLEN-1:0] rf_rs1_i,
  input  logic [`XLEN-1:0] rf_rs2_i,
  input  logic [`XLEN-1:0] ex_result_i,
  input  logic [`XLEN-1:0] mem_result_i,
  output logic [`XLEN-1:0] exe_rs1_o,
  output logic [`XLEN-1:0] exe_rs2_o
);

  logic [`XLEN-1:0] opnd1;
  logic [`XLEN-1:0] opnd2;

  function automatic logic [`XLEN-1:0] pick(input fwd_sel_e sel,
                                            input logic [`XLEN-1:0] rf_val,
                                            input logic [`XLEN-1:0] ex_val,
                                            input logic [`XLEN-1:0] mem_val);
    logic [`XLEN-1:0] val;
    case (sel)
      FWD_EX:  val = ex_val;
      FWD_MEM: val = mem_val;
      default: val = rf_val;
    endcase
    return val;
  endfunction

  assign opnd1 = pick(src1_sel_i, rf_rs1_i, ex_result_i, mem_result_i);
  assign opnd2 = pick(src2_sel_i, rf_rs2_i, ex_result_i, mem_result_i);

  // Decode-to-execute operand register.
  always_ff @(posedge clk)
  begin
    if (!rstn)
    begin
      exe_rs1_o <= `OPND_RST;
      exe_rs2_o <= `OPND_RST;
    end
    else if (de_st_i)
    begin
      exe_rs1_o <= exe_rs1_o;
      exe_rs2_o <= exe_rs2_o;
    end
    else if (flush_i)
    begin
      exe_rs1_o <= `OPND_RST;
      exe_rs2_o <= `OPND_RST;
    end
    else
    begin
      exe_rs1_o <= opnd1;
      exe_rs2_o <= opnd2;
    end
  end

endmodule

/* dv/pipe_ctrl_sva.sv */
module pipe_ctrl_sva (
  input logic clk,
  input logic rstn,
  input logic is_branch_i,
  input logic pre_taken_i,
  input logic m_arrival_i,
  input logic fd_st_i,
  input logic de_st_i,
  input logic em_st_i,
  input logic flush_i,
  input logic ptnt_early_i,
  input logic bptnt_i
);
  timeunit 1ns;
  timeprecision 1ps;

  // D-miss stall stays on in all three stages until the line arrives.
  dmiss_held: assert property (@(posedge clk) disable iff (!rstn)
                               em_st_i |=> m_arrival_i || (em_st_i && de_st_i && fd_st_i))
    else $error("D-miss stall dropped before arrival");

  // Load-use bubble lasts a single cycle.
  load_use_once: assert property (@(posedge clk) disable iff (!rstn)
                                  (de_st_i && !em_st_i) |=> (!de_st_i || em_st_i))
    else $error("load-use stall held past one cycle");

  // Mispredict flush follows the early hint of a predicted-taken branch.
  bptnt_after_early: assert property (@(posedge clk) disable iff (!rstn)
                                      bptnt_i |-> $past(ptnt_early_i) &&
                                                  $past(is_branch_i && pre_taken_i, 2))
    else $error("bptnt without an earlier predicted-taken branch and ptnt_early");

  quiet_after_reset: assert property (@(posedge clk)
                                      $rose(rstn) |-> !(flush_i || fd_st_i || de_st_i || em_st_i))
    else $error("flush or stall high in the first cycle after reset");

endmodule

bind hazard_ctrl pipe_ctrl_sva sva_i (
  .clk          (clk),
  .rstn         (rstn),
  .is_branch_i  (is_branch_i),
  .pre_taken_i  (pre_taken_i),
  .m_arrival_i  (m_arrival_i),
  .fd_st_i      (fd_st_o),
  .de_st_i      (de_st_o),
  .em_st_i      (em_st_o),
  .flush_i      (flush_o),
  .ptnt_early_i (ptnt_early_o),
  .bptnt_i      (bptnt_o)
);

/* dv/pipe_ctrl_tb.sv */
`include "core_params.svh"

module pipe_ctrl_tb
  import isa_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_CYCLES = 400;
  localparam logic [`INSTR_W-1:0] BUBBLE = '0;

  // Bit positions of the one-cycle event inputs.
  localparam int EV_PT    = 0;
  localparam int EV_FIN   = 1;
  localparam int EV_TRAP  = 2;
  localparam int EV_FMISS = 3;
  localparam int EV_MMISS = 4;
  localparam int EV_FARR  = 5;
  localparam int EV_MARR  = 6;

  logic                clk = 1'b0;
  logic                rstn;
  logic [`INSTR_W-1:0] instr;
  logic                pre_taken;
  logic                fin;
  logic                trap_flush;
  logic                f_cmiss;
  logic                m_cmiss;
  logic                f_arrival;
  logic                m_arrival;
  logic [`XLEN-1:0]    rf_rs1;
  logic [`XLEN-1:0]    rf_rs2;
  logic [`XLEN-1:0]    ex_result;
  logic [`XLEN-1:0]    mem_result;
  logic                fd_st_o;
  logic                de_st_o;
  logic                em_st_o;
  logic                flush_o;
  logic                rs1_depended_o;
  logic                ptnt_early_o;
  logic                bnt_taken_o;
  logic                bptrt_o;
  logic                bptnt_o;
  logic                real_taken_o;
  logic [`XLEN-1:0]    exe_rs1_o;
  logic [`XLEN-1:0]    exe_rs2_o;

  integer seed = 9339;
  int     errors = 0;
  int     checks = 0;
  int     cycle_cnt = 0;

  pipe_ctrl_top dut_i (
    .clk            (clk),
    .rstn           (rstn),
    .instr_i        (instr),
    .pre_taken_i    (pre_taken),
    .fin_i          (fin),
    .trap_flush_i   (trap_flush),
    .f_cmiss_i      (f_cmiss),
    .m_cmiss_i      (m_cmiss),
    .f_arrival_i    (f_arrival),
    .m_arrival_i    (m_arrival),
    .rf_rs1_i       (rf_rs1),
    .rf_rs2_i       (rf_rs2),
    .ex_result_i    (ex_result),
    .mem_result_i   (mem_result),
    .fd_st_o        (fd_st_o),
    .de_st_o        (de_st_o),
    .em_st_o        (em_st_o),
    .flush_o        (flush_o),
    .rs1_depended_o (rs1_depended_o),
    .ptnt_early_o   (ptnt_early_o),
    .bnt_taken_o    (bnt_taken_o),
    .bptrt_o        (bptrt_o),
    .bptnt_o        (bptnt_o),
    .real_taken_o   (real_taken_o),
    .exe_rs1_o      (exe_rs1_o),
    .exe_rs2_o      (exe_rs2_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("Timeout: run went past %0d cycles", MAX_CYCLES);
      $display("Some tests failed");
      $finish;
    end
  end

  function automatic logic [`INSTR_W-1:0] op_word(input logic [6:0] f7, input logic [2:0] f3,
                                                  input logic [`REG_AW-1:0] rd,
                                                  input logic [`REG_AW-1:0] rs1,
                                                  input logic [`REG_AW-1:0] rs2);
    instr_u u;
    u = '0;
    u.r_fmt.opcode = OPC_OP;
    u.r_fmt.funct7 = f7;
    u.r_fmt.funct3 = f3;
    u.r_fmt.rd     = rd;
    u.r_fmt.rs1    = rs1;
    u.r_fmt.rs2    = rs2;
    return u;
  endfunction

  function automatic logic [`INSTR_W-1:0] imm_word(input logic [6:0] opc, input logic [2:0] f3,
                                                   input logic [`REG_AW-1:0] rd,
                                                   input logic [`REG_AW-1:0] rs1,
                                                   input logic [11:0] imm);
    instr_u u;
    u = '0;
    u.i_fmt.opcode   = opc;
    u.i_fmt.funct3   = f3;
    u.i_fmt.rd       = rd;
    u.i_fmt.rs1      = rs1;
    u.i_fmt.imm_11_0 = imm;
    return u;
  endfunction

  function automatic logic [`INSTR_W-1:0] branch_word(input logic [2:0] f3,
                                                      input logic [`REG_AW-1:0] rs1,
                                                      input logic [`REG_AW-1:0] rs2);
    instr_u u;
    u = '0;
    u.b_fmt.opcode  = OPC_BRANCH;
    u.b_fmt.funct3  = f3;
    u.b_fmt.rs1     = rs1;
    u.b_fmt.rs2     = rs2;
    u.b_fmt.imm_4_1 = 4'h4;
    return u;
  endfunction

  function automatic logic [`INSTR_W-1:0] add_word(input logic [`REG_AW-1:0] rd,
                                                   input logic [`REG_AW-1:0] rs1,
                                                   input logic [`REG_AW-1:0] rs2);
    return op_word(7'h00, 3'b000, rd, rs1, rs2);
  endfunction

  function automatic logic [6:0] pulse(input int idx);
    return 7'b1 << idx;
  endfunction

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("ERR %s: expected 0x%h, got 0x%h at %0t", name, exp, act, $time);
    end
  endtask

  task automatic expect_stalls(input logic fd, input logic de, input logic em);
    expect_eq("fd_st_o", fd, fd_st_o);
    expect_eq("de_st_o", de, de_st_o);
    expect_eq("em_st_o", em, em_st_o);
  endtask

  // One cycle: new decode word and event pulses, then wait for settled outputs.
  task automatic drive(input logic [`INSTR_W-1:0] w, input logic [6:0] ev);
    @(posedge clk);
    instr      <= w;
    pre_taken  <= ev[EV_PT];
    fin        <= ev[EV_FIN];
    trap_flush <= ev[EV_TRAP];
    f_cmiss    <= ev[EV_FMISS];
    m_cmiss    <= ev[EV_MMISS];
    f_arrival  <= ev[EV_FARR];
    m_arrival  <= ev[EV_MARR];
    @(negedge clk);
  endtask

  task automatic set_values(input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b,
                            input logic [`XLEN-1:0] e, input logic [`XLEN-1:0] m);
    @(posedge clk);
    rf_rs1     <= a;
    rf_rs2     <= b;
    ex_result  <= e;
    mem_result <= m;
    @(negedge clk);
  endtask

  task automatic idle(input int n);
    repeat (n) drive(BUBBLE, '0);
  endtask

  task automatic test_forwarding();
    idle(2);
    set_values($random(seed), $random(seed), $random(seed), $random(seed));
    drive(add_word(5, 1, 2), '0);
    drive(add_word(6, 5, 5), '0);
    expect_eq("rs1_depended_o", 1, rs1_depended_o);
    drive(BUBBLE, '0);
    expect_eq("exe_rs1_o", ex_result, exe_rs1_o);
    expect_eq("exe_rs2_o", ex_result, exe_rs2_o);
    expect_eq("rs1_depended_o", 0, rs1_depended_o);
    // One bubble between writer and reader.
    drive(add_word(5, 1, 2), '0);
    drive(BUBBLE, '0);
    drive(add_word(7, 5, 0), '0);
    expect_eq("rs1_depended_o", 1, rs1_depended_o);
    drive(BUBBLE, '0);
    expect_eq("exe_rs1_o", mem_result, exe_rs1_o);
    expect_eq("exe_rs2_o", rf_rs2, exe_rs2_o);
    drive(add_word(0, 1, 2), '0);
    drive(add_word(8, 0, 3), '0);
    expect_eq("rs1_depended_o", 0, rs1_depended_o);
    drive(BUBBLE, '0);
    expect_eq("exe_rs1_o", rf_rs1, exe_rs1_o);
    expect_eq("exe_rs2_o", rf_rs2, exe_rs2_o);
  endtask

  task automatic test_load_use();
    idle(2);
    drive(imm_word(OPC_LOAD, 3'b010, 9, 1, 12'h010), '0);
    drive(add_word(10, 9, 2), '0);
    expect_stalls(1'b1, 1'b1, 1'b0);
    // Decode holds the dependent add for one more cycle.
    drive(add_word(10, 9, 2), '0);
    expect_stalls(1'b0, 1'b0, 1'b0);
    expect_eq("rs1_depended_o", 1, rs1_depended_o);
    drive(BUBBLE, '0);
    expect_eq("exe_rs1_o", mem_result, exe_rs1_o);
    expect_eq("exe_rs2_o", rf_rs2, exe_rs2_o);
  endtask

  task automatic miss_case(input logic is_data);
    int d;
    int k;
    d = 2 + ($unsigned($random(seed)) % 4);
    idle(1);
    drive(BUBBLE, pulse(is_data ? EV_MMISS : EV_FMISS));
    expect_stalls(1'b1, is_data, is_data);
    for (k = 1; k < d; k++)
    begin
      drive(BUBBLE, '0);
      expect_stalls(1'b1, is_data, is_data);
    end
    drive(BUBBLE, pulse(is_data ? EV_MARR : EV_FARR));
    expect_stalls(1'b0, 1'b0, 1'b0);
    drive(BUBBLE, '0);
    expect_stalls(1'b0, 1'b0, 1'b0);
  endtask

  task automatic long_case(input logic [`INSTR_W-1:0] w);
    int d;
    int k;
    d = 2 + ($unsigned($random(seed)) % 4);
    idle(1);
    for (k = 0; k < d; k++)
    begin
      drive(w, '0);
      expect_stalls(1'b1, 1'b0, 1'b0);
    end
    drive(w, pulse(EV_FIN));
    expect_stalls(1'b0, 1'b0, 1'b0);
    drive(BUBBLE, '0);
    expect_stalls(1'b0, 1'b0, 1'b0);
  endtask

  task automatic branch_case(input logic [2:0] f3, input logic [`XLEN-1:0] a,
                             input logic [`XLEN-1:0] b, input logic pt);
    logic taken;
    taken = (f3 == F3_BEQ) ? (a == b) : ($signed(a) < $signed(b));
    idle(1);
    set_values(a, b, ex_result, mem_result);
    drive(branch_word(f3, 1, 2), pt ? pulse(EV_PT) : 7'b0);
    expect_eq("flush_o", 0, flush_o);
    drive(BUBBLE, '0);
    expect_eq("real_taken_o", taken, real_taken_o);
    expect_eq("flush_o", taken, flush_o);
    expect_eq("bptrt_o", pt && taken, bptrt_o);
    expect_eq("ptnt_early_o", pt && !taken, ptnt_early_o);
    expect_eq("bptnt_o", 0, bptnt_o);
    expect_eq("bnt_taken_o", 0, bnt_taken_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", pt != taken, flush_o);
    expect_eq("bptnt_o", pt && !taken, bptnt_o);
    expect_eq("bnt_taken_o", !pt && taken, bnt_taken_o);
    expect_eq("bptrt_o", 0, bptrt_o);
    expect_eq("ptnt_early_o", 0, ptnt_early_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", 0, flush_o);
    expect_eq("bptnt_o", 0, bptnt_o);
    expect_eq("bnt_taken_o", 0, bnt_taken_o);
  endtask

  task automatic test_branches();
    logic [`XLEN-1:0] v;
    logic [`XLEN-1:0] pos;
    logic [`XLEN-1:0] neg;
    v   = $random(seed);
    pos = $random(seed) & 32'h7fff_ffff;
    neg = $random(seed) | 32'h8000_0000;
    branch_case(F3_BEQ, v, v, 1'b1);
    branch_case(F3_BLT, pos, neg, 1'b1);
    branch_case(F3_BLT, neg, pos, 1'b0);
    branch_case(F3_BEQ, v, v ^ 32'h1, 1'b0);
  endtask

  task automatic test_redirects();
    idle(2);
    drive(imm_word(OPC_JAL, 3'b000, 1, 0, 12'h000), '0);
    expect_eq("flush_o", 0, flush_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", 1, flush_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", 0, flush_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", 0, flush_o);
    // Jump whose base register comes through the bypass.
    drive(add_word(12, 1, 2), '0);
    drive(imm_word(OPC_JALR, 3'b000, 1, 12, 12'h000), '0);
    expect_eq("rs1_depended_o", 1, rs1_depended_o);
    expect_eq("flush_o", 0, flush_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", 1, flush_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", 0, flush_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", 1, flush_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", 0, flush_o);
    drive(imm_word(OPC_SYSTEM, 3'b000, 0, 0, F12_MRET), '0);
    expect_eq("flush_o", 1, flush_o);
    drive(BUBBLE, '0);
    expect_eq("flush_o", 0, flush_o);
    // Trap drops the destination records for two cycles.
    idle(1);
    drive(add_word(13, 1, 2), '0);
    drive(add_word(13, 1, 2), pulse(EV_TRAP));
    drive(add_word(13, 13, 0), '0);
    expect_eq("rs1_depended_o", 0, rs1_depended_o);
    drive(add_word(14, 13, 0), '0);
    expect_eq("rs1_depended_o", 0, rs1_depended_o);
    expect_eq("exe_rs1_o", rf_rs1, exe_rs1_o);
    drive(add_word(15, 14, 0), '0);
    expect_eq("rs1_depended_o", 1, rs1_depended_o);
    drive(BUBBLE, '0);
    expect_eq("exe_rs1_o", ex_result, exe_rs1_o);
  endtask

  initial
  begin
    rstn       = 1'b0;
    instr      = BUBBLE;
    pre_taken  = 1'b0;
    fin        = 1'b0;
    trap_flush = 1'b0;
    f_cmiss    = 1'b0;
    m_cmiss    = 1'b0;
    f_arrival  = 1'b0;
    m_arrival  = 1'b0;
    rf_rs1     = '0;
    rf_rs2     = '0;
    ex_result  = '0;
    mem_result = '0;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
    @(negedge clk);
    expect_stalls(1'b0, 1'b0, 1'b0);
    expect_eq("flush_o", 0, flush_o);
    expect_eq("bptnt_o", 0, bptnt_o);
    expect_eq("exe_rs1_o", 0, exe_rs1_o);
    expect_eq("exe_rs2_o", 0, exe_rs2_o);
    test_forwarding();
    test_load_use();
    miss_case(1'b0);
    miss_case(1'b1);
    long_case(op_word(FUNCT7_MULDIV, 3'b000, 11, 1, 2));
    long_case(op_word(FUNCT7_MULDIV, 3'b100, 12, 3, 4));
    test_branches();
    test_redirects();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

/* list.f */
+incdir+design
design/isa_pkg.sv
design/pipe_ctrl_pkg.sv
design/instr_decode.sv
design/hazard_ctrl.sv
design/result_bypass.sv
design/branch_resolve.sv
design/pipe_ctrl_top.sv
dv/pipe_ctrl_sva.sv
dv/pipe_ctrl_tb.sv
